//--- design/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // basic widths of the front end
    typedef logic [31:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [6:0]  ecode_t;

    // one decoded-ready slot as stored in an instruction queue bank
    typedef struct packed {
        pc_t    pc;
        inst_t  inst;
        logic   excp;
        ecode_t ecode;
        pc_t    badv;
    } fetch_entry_t;

    // andi r0, r0, 0
    localparam inst_t inst_nop = 32'h0340_0000;

    // one bank per slot of a fetch pair
    localparam int num_banks   = 2;
    localparam int bank_depth  = 4;
    // outstanding fetch addresses
    localparam int track_depth = 4;

    // bank rotation index
    typedef logic [$clog2(num_banks)-1:0] bank_idx_t;

    // step a rotation pointer to the following bank
    function automatic bank_idx_t next_bank(input bank_idx_t idx);
        bank_idx_t nxt;
        if (idx == bank_idx_t'(num_banks - 1)) begin
            nxt = '0;
        end else begin
            nxt = idx + 1'b1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

//--- design/fetch_fifo.sv
`default_nettype none

module fetch_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = 4
) (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     flush,
    input  wire logic     push,
    input  wire payload_t din,
    input  wire logic     pop,
    output payload_t      dout,
    output logic          full,
    output logic          empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] wrap_inc(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] nxt;
        if (ptr == ptr_w'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full    = (count == cnt_w'(depth));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // show-ahead head
    assign dout = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wrap_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= wrap_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/if1_stage.sv
`default_nettype none

module if1_stage (
    input  wire logic                                            clk,
    input  wire logic                                            rstn,
    input  wire logic                                            flush,
    input  wire logic                                            fetch_valid,
    input  wire fetch_pkg::pc_t                                  fetch_pc,
    output logic                                                 fetch_allowin,
    input  wire logic                                            resp_valid,
    input  wire fetch_pkg::pc_t                                  resp_pc,
    input  wire fetch_pkg::inst_t                                resp_inst0,
    input  wire fetch_pkg::inst_t                                resp_inst1,
    input  wire logic [1:0]                                      resp_excp_flag,
    input  wire fetch_pkg::ecode_t                               resp_ecode,
    input  wire fetch_pkg::pc_t                                  resp_badv,
    output logic                                                 resp_allowin,
    output logic                                                 track_push,
    output fetch_pkg::pc_t                                       track_din,
    output logic                                                 track_pop,
    input  wire fetch_pkg::pc_t                                  track_head,
    input  wire logic                                            track_full,
    output logic [fetch_pkg::num_banks-1:0]                      bank_push,
    output fetch_pkg::fetch_entry_t [fetch_pkg::num_banks-1:0]   bank_din,
    input  wire logic [fetch_pkg::num_banks-1:0]                 bank_full
);

    logic                  stage_valid;
    fetch_pkg::pc_t        stage_pc;
    fetch_pkg::inst_t      stage_inst0;
    fetch_pkg::inst_t      stage_inst1;
    logic [1:0]            stage_flag;
    fetch_pkg::ecode_t     stage_ecode;
    fetch_pkg::pc_t        stage_badv;
    fetch_pkg::bank_idx_t  wr_ptr;
    fetch_pkg::bank_idx_t  wr_ptr_nxt;
    fetch_pkg::fetch_entry_t entry0;
    fetch_pkg::fetch_entry_t entry1;
    logic                  take;
    logic                  drain;
    logic                  stale;
    logic                  write;
    logic                  two;

    // every accepted fetch address is remembered in order
    assign fetch_allowin = !track_full;
    assign track_push    = fetch_valid && fetch_allowin;
    assign track_din     = fetch_pc;

    // stage leaves at the first edge with room in every bank
    assign drain = stage_valid && (bank_full == '0);
    // bit 2 only selects the slot, the pair shares one tracked address
    assign stale = {stage_pc[31:3], stage_pc[1:0]} != {track_head[31:3], track_head[1:0]};
    assign write = drain && !stale;
    assign track_pop = write;

    assign resp_allowin = !stage_valid || drain;
    assign take         = resp_valid && resp_allowin;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (take) begin
            stage_valid <= 1'b1;
        end else if (drain) begin
            stage_valid <= 1'b0;
        end
    end

    // pair is aligned on capture, upper word alone when pc[2] is set
    always_ff @(posedge clk) begin
        if (take) begin
            stage_pc    <= resp_pc;
            stage_inst0 <= resp_pc[2] ? resp_inst1 : resp_inst0;
            stage_inst1 <= resp_pc[2] ? fetch_pkg::inst_nop : resp_inst1;
            stage_flag  <= resp_pc[2] ? {1'b0, resp_excp_flag[1]} : resp_excp_flag;
            stage_ecode <= resp_ecode;
            stage_badv  <= resp_badv;
        end
    end

    assign two = !stage_pc[2];

    always_comb begin
        entry0.pc    = stage_pc;
        entry0.inst  = stage_inst0;
        entry0.excp  = stage_flag[0];
        entry0.ecode = stage_flag[0] ? stage_ecode : '0;
        entry0.badv  = stage_badv;
        entry1.pc    = stage_pc + 32'd4;
        entry1.inst  = stage_inst1;
        entry1.excp  = stage_flag[1];
        entry1.ecode = stage_flag[1] ? stage_ecode : '0;
        entry1.badv  = stage_badv;
    end

    assign wr_ptr_nxt = fetch_pkg::next_bank(wr_ptr);

    // first slot under the pointer, second slot in the bank after it
    always_comb begin
        bank_push = '0;
        bank_din  = {fetch_pkg::num_banks{entry0}};
        if (write) begin
            bank_push[wr_ptr] = 1'b1;
            if (two) begin
                bank_push[wr_ptr_nxt] = 1'b1;
                bank_din[wr_ptr_nxt]  = entry1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= two ? fetch_pkg::next_bank(wr_ptr_nxt) : wr_ptr_nxt;
        end
    end

endmodule

`default_nettype wire

//--- design/inst_drain.sv
`default_nettype none

module inst_drain (
    input  wire logic                                            clk,
    input  wire logic                                            rstn,
    input  wire logic                                            flush,
    input  wire fetch_pkg::fetch_entry_t [fetch_pkg::num_banks-1:0] bank_dout,
    input  wire logic [fetch_pkg::num_banks-1:0]                 bank_empty,
    output logic [fetch_pkg::num_banks-1:0]                      bank_pop,
    output logic                                                 out_valid,
    output fetch_pkg::pc_t                                       out_pc,
    output fetch_pkg::inst_t                                     out_inst,
    output logic                                                 out_excp,
    output fetch_pkg::ecode_t                                    out_ecode,
    output fetch_pkg::pc_t                                       out_badv,
    input  wire logic                                            out_allowin
);

    fetch_pkg::bank_idx_t    rd_ptr;
    fetch_pkg::fetch_entry_t head;
    logic                    fire;

    // head of the bank next in program order
    assign head      = bank_dout[rd_ptr];
    assign out_valid = !bank_empty[rd_ptr];
    assign out_pc    = head.pc;
    assign out_inst  = head.inst;
    assign out_excp  = head.excp;
    assign out_ecode = head.ecode;
    assign out_badv  = head.badv;

    assign fire = out_valid && out_allowin;

    always_comb begin
        bank_pop         = '0;
        bank_pop[rd_ptr] = fire;
    end

    // same rotation as the writer, so order is restored
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
        end else if (fire) begin
            rd_ptr <= fetch_pkg::next_bank(rd_ptr);
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_queue_top.sv
`default_nettype none

module fetch_queue_top (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              flush,
    input  wire logic              fetch_valid,
    input  wire fetch_pkg::pc_t    fetch_pc,
    output logic                   fetch_allowin,
    input  wire logic              resp_valid,
    input  wire fetch_pkg::pc_t    resp_pc,
    input  wire fetch_pkg::inst_t  resp_inst0,
    input  wire fetch_pkg::inst_t  resp_inst1,
    input  wire logic [1:0]        resp_excp_flag,
    input  wire fetch_pkg::ecode_t resp_ecode,
    input  wire fetch_pkg::pc_t    resp_badv,
    output logic                   resp_allowin,
    output logic                   out_valid,
    output fetch_pkg::pc_t         out_pc,
    output fetch_pkg::inst_t       out_inst,
    output logic                   out_excp,
    output fetch_pkg::ecode_t      out_ecode,
    output fetch_pkg::pc_t         out_badv,
    input  wire logic              out_allowin
);

    logic                                              track_push;
    logic                                              track_pop;
    fetch_pkg::pc_t                                    track_din;
    fetch_pkg::pc_t                                    track_head;
    logic                                              track_full;
    logic [fetch_pkg::num_banks-1:0]                   bank_push;
    logic [fetch_pkg::num_banks-1:0]                   bank_pop;
    logic [fetch_pkg::num_banks-1:0]                   bank_full;
    logic [fetch_pkg::num_banks-1:0]                   bank_empty;
    fetch_pkg::fetch_entry_t [fetch_pkg::num_banks-1:0] bank_din;
    fetch_pkg::fetch_entry_t [fetch_pkg::num_banks-1:0] bank_dout;

    // outstanding fetch addresses, oldest at the head
    fetch_fifo #(
        .payload_t (fetch_pkg::pc_t),
        .depth     (fetch_pkg::track_depth)
    ) u_tracker (
        .clk   (clk),
        .rstn  (rstn),
        .flush (flush),
        .push  (track_push),
        .din   (track_din),
        .pop   (track_pop),
        .dout  (track_head),
        .full  (track_full),
        .empty ()
    );

    if1_stage u_if1_stage (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_allowin  (fetch_allowin),
        .resp_valid     (resp_valid),
        .resp_pc        (resp_pc),
        .resp_inst0     (resp_inst0),
        .resp_inst1     (resp_inst1),
        .resp_excp_flag (resp_excp_flag),
        .resp_ecode     (resp_ecode),
        .resp_badv      (resp_badv),
        .resp_allowin   (resp_allowin),
        .track_push     (track_push),
        .track_din      (track_din),
        .track_pop      (track_pop),
        .track_head     (track_head),
        .track_full     (track_full),
        .bank_push      (bank_push),
        .bank_din       (bank_din),
        .bank_full      (bank_full)
    );

    // one instruction queue bank per slot
    for (genvar g = 0; g < fetch_pkg::num_banks; g++) begin : g_bank
        fetch_fifo #(
            .payload_t (fetch_pkg::fetch_entry_t),
            .depth     (fetch_pkg::bank_depth)
        ) u_bank (
            .clk   (clk),
            .rstn  (rstn),
            .flush (flush),
            .push  (bank_push[g]),
            .din   (bank_din[g]),
            .pop   (bank_pop[g]),
            .dout  (bank_dout[g]),
            .full  (bank_full[g]),
            .empty (bank_empty[g])
        );
    end

    inst_drain u_inst_drain (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .bank_dout   (bank_dout),
        .bank_empty  (bank_empty),
        .bank_pop    (bank_pop),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_excp    (out_excp),
        .out_ecode   (out_ecode),
        .out_badv    (out_badv),
        .out_allowin (out_allowin)
    );

endmodule

`default_nettype wire

//--- bench/fetch_queue_assertions.sv
`default_nettype none

module fetch_queue_assertions (
    input wire logic                            clk,
    input wire logic                            rstn,
    input wire logic                            flush,
    input wire logic                            out_valid,
    input wire logic                            out_allowin,
    input wire fetch_pkg::pc_t                  out_pc,
    input wire fetch_pkg::inst_t                out_inst,
    input wire logic                            out_excp,
    input wire fetch_pkg::ecode_t               out_ecode,
    input wire fetch_pkg::pc_t                  out_badv,
    input wire logic                            resp_allowin,
    input wire logic                            stage_valid,
    input wire logic [fetch_pkg::num_banks-1:0] bank_full
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failures = 0;

    // nothing reaches the decoder straight out of reset
    quiet_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !out_valid)
        else begin
            $error("out_valid high right after reset");
            failures++;
        end

    // stalled decoder sees the same instruction until it takes it
    hold_under_stall: assert property (@(posedge clk) disable iff (!rstn || flush)
        out_valid && !out_allowin && !flush
            |=> out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_excp)
            && $stable(out_ecode) && $stable(out_badv))
        else begin
            $error("decoder outputs changed while stalled");
            failures++;
        end

    // a blocked stage refuses new responses and keeps its entry
    block_resp: assert property (@(posedge clk) disable iff (!rstn || flush)
        stage_valid && (bank_full != '0) && !flush |=> stage_valid && !$past(resp_allowin))
        else begin
            $error("resp_allowin high or entry lost while the stage cannot write");
            failures++;
        end

endmodule

bind fetch_queue_top fetch_queue_assertions u_assertions (
    .clk          (clk),
    .rstn         (rstn),
    .flush        (flush),
    .out_valid    (out_valid),
    .out_allowin  (out_allowin),
    .out_pc       (out_pc),
    .out_inst     (out_inst),
    .out_excp     (out_excp),
    .out_ecode    (out_ecode),
    .out_badv     (out_badv),
    .resp_allowin (resp_allowin),
    .stage_valid  (u_if1_stage.stage_valid),
    .bank_full    (bank_full)
);

`default_nettype wire

//--- bench/fetch_queue_tb.sv
`default_nettype none

module fetch_queue_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // each golden record is one op word and six argument words
    localparam int rec_words = 7;
    localparam int max_recs  = 64;

    logic              clk;
    logic              rstn;
    logic              flush;
    logic              fetch_valid;
    fetch_pkg::pc_t    fetch_pc;
    logic              fetch_allowin;
    logic              resp_valid;
    fetch_pkg::pc_t    resp_pc;
    fetch_pkg::inst_t  resp_inst0;
    fetch_pkg::inst_t  resp_inst1;
    logic [1:0]        resp_excp_flag;
    fetch_pkg::ecode_t resp_ecode;
    fetch_pkg::pc_t    resp_badv;
    logic              resp_allowin;
    logic              out_valid;
    fetch_pkg::pc_t    out_pc;
    fetch_pkg::inst_t  out_inst;
    logic              out_excp;
    fetch_pkg::ecode_t out_ecode;
    fetch_pkg::pc_t    out_badv;
    logic              out_allowin;

    logic [31:0]             golden [0:rec_words*max_recs-1];
    fetch_pkg::pc_t          track_q [$];
    fetch_pkg::fetch_entry_t model_q [$];
    fetch_pkg::fetch_entry_t model_log [$];
    int                      num_recs;
    int                      gold_idx;
    int                      cycle_limit;
    int                      cycles;
    int                      stall_left;
    bit                      rand_stall;
    int                      seed;
    int                      errors;
    int                      checks;
    int                      tests;
    int                      test_checks;
    int                      test_errors;

    fetch_queue_top i_fetch_queue_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_inst(input string what,
                              input fetch_pkg::pc_t exp_pc, input fetch_pkg::inst_t exp_inst,
                              input fetch_pkg::pc_t got_pc, input fetch_pkg::inst_t got_inst);
        checks++;
        if (got_pc !== exp_pc || got_inst !== exp_inst) begin
            $display("[FAIL] %0t %s: expected %h at pc %h, got %h at pc %h",
                     $time, what, exp_inst, exp_pc, got_inst, got_pc);
            errors++;
        end
    endtask

    task automatic check_excp(input string what, input logic exp_excp,
                              input fetch_pkg::ecode_t exp_ecode, input fetch_pkg::pc_t exp_badv,
                              input logic got_excp, input fetch_pkg::ecode_t got_ecode,
                              input fetch_pkg::pc_t got_badv);
        checks++;
        if (got_excp !== exp_excp || got_ecode !== exp_ecode || got_badv !== exp_badv) begin
            $display("[FAIL] %0t %s: expected excp %b code %h badv %h, got %b %h %h",
                     $time, what, exp_excp, exp_ecode, exp_badv, got_excp, got_ecode, got_badv);
            errors++;
        end
    endtask

    function automatic fetch_pkg::fetch_entry_t make_entry(input fetch_pkg::pc_t pc,
            input fetch_pkg::inst_t inst, input logic flag, input fetch_pkg::ecode_t ecode,
            input fetch_pkg::pc_t badv);
        fetch_pkg::fetch_entry_t e;
        e.pc    = pc;
        e.inst  = inst;
        e.excp  = flag;
        // unflagged slots carry code zero
        e.ecode = flag ? ecode : 7'd0;
        e.badv  = badv;
        return e;
    endfunction

    task automatic expect_entry(input fetch_pkg::fetch_entry_t e);
        model_q.push_back(e);
        model_log.push_back(e);
    endtask

    // reference model of one accepted response
    task automatic predict_response(input fetch_pkg::pc_t pc, input fetch_pkg::inst_t inst0,
                                    input fetch_pkg::inst_t inst1, input logic [1:0] flags,
                                    input fetch_pkg::ecode_t ecode, input fetch_pkg::pc_t badv);
        fetch_pkg::pc_t mask;
        mask = 32'hffff_fffb;
        // stale unless it matches the oldest outstanding fetch
        if (track_q.size() != 0 && (track_q[0] & mask) == (pc & mask)) begin
            track_q.delete(0);
            if (!pc[2]) begin
                expect_entry(make_entry(pc, inst0, flags[0], ecode, badv));
                expect_entry(make_entry(pc + 32'd4, inst1, flags[1], ecode, badv));
            end else begin
                expect_entry(make_entry(pc, inst1, flags[1], ecode, badv));
            end
        end
    endtask

    task automatic drop_pending();
        // pending entries are always the newest ones in the log
        repeat (model_q.size()) model_log.delete(model_log.size() - 1);
        model_q.delete();
        track_q.delete();
    endtask

    task automatic issue_fetch(input fetch_pkg::pc_t pc);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= pc;
        @(negedge clk);
        while (!fetch_allowin) @(negedge clk);
        @(posedge clk);
        fetch_valid <= 1'b0;
        track_q.push_back(pc);
        @(negedge clk);
        // a full tracker has to refuse further fetches
        if (track_q.size() == fetch_pkg::track_depth) begin
            checks++;
            if (fetch_allowin !== 1'b0) begin
                $display("[FAIL] %0t fetch_allowin high with %0d fetches outstanding",
                         $time, track_q.size());
                errors++;
            end
        end
    endtask

    task automatic send_response(input fetch_pkg::pc_t pc, input fetch_pkg::inst_t inst0,
                                 input fetch_pkg::inst_t inst1, input logic [1:0] flags,
                                 input fetch_pkg::ecode_t ecode, input fetch_pkg::pc_t badv);
        @(posedge clk);
        resp_valid     <= 1'b1;
        resp_pc        <= pc;
        resp_inst0     <= inst0;
        resp_inst1     <= inst1;
        resp_excp_flag <= flags;
        resp_ecode     <= ecode;
        resp_badv      <= badv;
        @(negedge clk);
        while (!resp_allowin) @(negedge clk);
        @(posedge clk);
        resp_valid <= 1'b0;
        predict_response(pc, inst0, inst1, flags, ecode, badv);
    endtask

    task automatic apply_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        drop_pending();
        @(negedge clk);
        checks++;
        if (out_valid) begin
            $display("[FAIL] %0t out_valid is still high after the flush", $time);
            errors++;
        end
    endtask

    // cross-check of the model against the golden stream
    task automatic compare_golden(input fetch_pkg::pc_t pc, input fetch_pkg::inst_t inst,
                                  input logic excp, input fetch_pkg::ecode_t ecode,
                                  input fetch_pkg::pc_t badv);
        fetch_pkg::fetch_entry_t m;
        if (gold_idx >= model_log.size()) begin
            $display("ERROR: %0t golden entry at pc %h has no match in the model", $time, pc);
            errors++;
        end else begin
            m = model_log[gold_idx];
            check_inst("golden vs model", pc, inst, m.pc, m.inst);
            check_excp("golden vs model", excp, ecode, badv, m.excp, m.ecode, m.badv);
        end
        gold_idx++;
    endtask

    task automatic finish_test(input logic [31:0] num);
        while (model_q.size() != 0) @(negedge clk);
        // two edges cover a stale response still in the stage
        repeat (2) @(negedge clk);
        if (out_valid) begin
            $display("ERROR: %0t an instruction is left in the queue at the end of test %0d",
                     $time, num);
            errors++;
        end
        if (gold_idx != model_log.size()) begin
            $display("ERROR: golden stream and model differ in length in test %0d", num);
            errors++;
        end
        tests++;
        $display("test %0d finished: %0d checks, %0d errors",
                 num, checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic run_record(input int base);
        logic [31:0] op;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] a5;
        op = golden[base];
        a0 = golden[base + 1];
        a1 = golden[base + 2];
        a2 = golden[base + 3];
        a3 = golden[base + 4];
        a4 = golden[base + 5];
        a5 = golden[base + 6];
        case (op)
            32'd1: issue_fetch(a0);
            32'd2: send_response(a0, a1, a2, a3[1:0], a4[6:0], a5);
            32'd3: apply_flush();
            32'd4: begin
                // a new stall pattern starts once the pending instructions have drained
                while (model_q.size() != 0) @(negedge clk);
                @(negedge clk);
                stall_left = a0;
                rand_stall = a1[0];
            end
            32'd5: compare_golden(a0, a1, a2[0], a3[6:0], a4);
            32'd6: finish_test(a0);
            default: begin
                $display("ERROR: unknown record type %h at record %0d", op, base / rec_words);
                errors++;
            end
        endcase
    endtask

    // decoder back-pressure
    initial begin
        out_allowin = 1'b1;
        forever begin
            @(posedge clk);
            if (stall_left > 0) begin
                out_allowin <= 1'b0;
                stall_left = stall_left - 1;
            end else if (rand_stall) begin
                out_allowin <= ($random(seed) % 4) != 0;
            end else begin
                out_allowin <= 1'b1;
            end
        end
    end

    // every handshake with the decoder is checked against the model
    initial begin : monitor
        fetch_pkg::fetch_entry_t exp;
        forever begin
            @(negedge clk);
            if (rstn && out_valid && out_allowin) begin
                if (model_q.size() == 0) begin
                    $display("ERROR: %0t unexpected instruction at pc %h", $time, out_pc);
                    errors++;
                end else begin
                    exp = model_q.pop_front();
                    check_inst("decoder output", exp.pc, exp.inst, out_pc, out_inst);
                    check_excp("decoder output", exp.excp, exp.ecode, exp.badv,
                               out_excp, out_ecode, out_badv);
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, the run did not complete", cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin : run
        seed           = 92;
        rstn           = 1'b0;
        flush          = 1'b0;
        fetch_valid    = 1'b0;
        fetch_pc       = '0;
        resp_valid     = 1'b0;
        resp_pc        = '0;
        resp_inst0     = '0;
        resp_inst1     = '0;
        resp_excp_flag = '0;
        resp_ecode     = '0;
        resp_badv      = '0;
        $readmemh("bench/fetch_golden.txt", golden);
        num_recs = 0;
        while (num_recs < max_recs && golden[num_recs*rec_words] != 0) begin
            num_recs++;
        end
        cycle_limit = 40 * num_recs;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        for (int r = 0; r < num_recs; r++) begin
            run_record(r * rec_words);
        end
        if (i_fetch_queue_top.u_assertions.failures != 0) begin
            $display("ERROR: %0d assertion failures", i_fetch_queue_top.u_assertions.failures);
            errors++;
        end
        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/fetch_golden.txt
// hex columns: op a0 a1 a2 a3 a4 a5; op 1 fetch pc, 2 resp pc inst0 inst1 flags ecode badv
// op 3 flush, 4 stall cycles random_on, 5 expect pc inst excp ecode badv, 6 end of test n, 0 end
1 00001000 0 0 0 0 0
2 00001000 00100013 00200013 0 0 0
5 00001000 00100013 0 0 0 0
5 00001004 00200013 0 0 0 0
6 1 0 0 0 0 0
1 0000100c 0 0 0 0 0
2 0000100c 00300013 00400013 1 08 0000100c
5 0000100c 00400013 0 0 0000100c 0
6 2 0 0 0 0 0
1 00002000 0 0 0 0 0
2 00003000 00500013 00600013 0 0 0
2 00002000 00700013 00800013 0 0 0
5 00002000 00700013 0 0 0 0
5 00002004 00800013 0 0 0 0
6 3 0 0 0 0 0
4 0000001e 1 0 0 0 0
1 00004000 0 0 0 0 0
1 00004008 0 0 0 0 0
1 00004010 0 0 0 0 0
1 00004018 0 0 0 0 0
2 00004000 01000013 01100013 0 0 0
2 00004008 01200013 01300013 0 0 0
2 00004010 01400013 01500013 0 0 0
2 00004018 01600013 01700013 0 0 0
1 00004020 0 0 0 0 0
2 00004020 01800013 01900013 0 0 0
5 00004000 01000013 0 0 0 0
5 00004004 01100013 0 0 0 0
5 00004008 01200013 0 0 0 0
5 0000400c 01300013 0 0 0 0
5 00004010 01400013 0 0 0 0
5 00004014 01500013 0 0 0 0
5 00004018 01600013 0 0 0 0
5 0000401c 01700013 0 0 0 0
5 00004020 01800013 0 0 0 0
5 00004024 01900013 0 0 0 0
4 0 0 0 0 0 0
6 4 0 0 0 0 0
1 00005000 0 0 0 0 0
2 00005000 02000013 02100013 2 0a 00005004
5 00005000 02000013 0 0 00005004 0
5 00005004 02100013 1 0a 00005004 0
6 5 0 0 0 0 0
4 00000028 0 0 0 0 0
1 00006000 0 0 0 0 0
1 00006008 0 0 0 0 0
2 00006000 03000013 03100013 0 0 0
3 0 0 0 0 0 0
1 00007000 0 0 0 0 0
2 00007000 03200013 03300013 0 0 0
5 00007000 03200013 0 0 0 0
5 00007004 03300013 0 0 0 0
6 6 0 0 0 0 0
0 0 0 0 0 0 0

//--- build.f
design/fetch_pkg.sv
design/fetch_fifo.sv
design/if1_stage.sv
design/inst_drain.sv
design/fetch_queue_top.sv
bench/fetch_queue_assertions.sv
bench/fetch_queue_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module fetch_queue_tb -Mdir "$build_dir" -f build.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/Vfetch_queue_tb" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST FAILED \*\*\*" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi

echo "simulation finished without failures"
exit 0
